/* verilog/periph_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Peripheral package
// Host bus request and read word, region map, UART write opcodes,
// baud and FIFO sizing, receive FIFO entry and control offsets.
//////////////////////////////////////////////////////////////////////

package periph_pkg;

   // one host access, byte enables double as the write strobe
   typedef struct packed {
      logic        en;
      logic [7:0]  we;
      logic [17:0] addr;
      logic [63:0] wdata;
   } host_req_t;

   typedef logic [63:0] host_rdata_t;

   // region field is addr[17:15]
   localparam int REGION_W = 3;
   localparam logic [REGION_W-1:0] REGION_UART = 3'd0;
   localparam logic [REGION_W-1:0] REGION_CTRL = 3'd2;

   // addr[14] picks UART registers over the keyboard sub-range
   localparam int UART_SEL_BIT = 14;

   // addr[13:12] on a UART write
   localparam logic [1:0] UART_OP_TX   = 2'd0;
   localparam logic [1:0] UART_OP_POP  = 2'd1;
   localparam logic [1:0] UART_OP_BAUD = 2'd2;

   localparam int BAUD_W = 16;
   localparam logic [BAUD_W-1:0] UART_BAUD_RESET = 16'd54; // clocks per bit

   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = 12;                        // free-running counters

   // receive FIFO entry
   typedef struct packed {
      logic       err;
      logic [7:0] data;
   } uart_rx_word_t;

   // word offsets in addr[7:3] of the control region
   localparam logic [4:0] CTRL_LED_OFS = 5'd15;
   localparam logic [4:0] CTRL_DIP_OFS = 5'd31;

endpackage

/* verilog/sync_fifo.sv */
//////////////////////////////////////////////////////////////////////
// Single-clock FIFO
// Circular buffer with first-word fall-through output, full/empty
// flags and free-running write and read counters.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sync_fifo
   import periph_pkg::*;
#(
   parameter int WIDTH = 9
)
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  logic                  push_i,
   input  logic                  pop_i,
   input  logic [WIDTH-1:0]      din_i,
   output logic [WIDTH-1:0]      dout_o,
   output logic                  full_o,
   output logic                  empty_o,
   output logic [FIFO_CNT_W-1:0] wr_cnt_o,
   output logic [FIFO_CNT_W-1:0] rd_cnt_o
);

   logic [WIDTH-1:0]      mem [FIFO_DEPTH];
   logic [FIFO_CNT_W-1:0] wr_cnt;
   logic [FIFO_CNT_W-1:0] rd_cnt;
   logic [FIFO_CNT_W-1:0] level;
   logic                  do_push;
   logic                  do_pop;

   // depth is far below the counter range, so the difference is the fill level
   assign level   = wr_cnt - rd_cnt;
   assign full_o  = (level == FIFO_CNT_W'(FIFO_DEPTH));
   assign empty_o = (level == '0);

   assign do_push = push_i & ~full_o;        // full drops the push
   assign do_pop  = pop_i & ~empty_o;        // empty ignores the pop

   assign dout_o   = mem[rd_cnt[FIFO_PTR_W-1:0]]; // head entry
   assign wr_cnt_o = wr_cnt;
   assign rd_cnt_o = rd_cnt;

   always_ff @(posedge msoc_clk)
   begin
      if (do_push)
      begin
         mem[wr_cnt[FIFO_PTR_W-1:0]] <= din_i;
      end
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_cnt <= '0;
         rd_cnt <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_cnt <= wr_cnt + 1'b1;
         end
         if (do_pop)
         begin
            rd_cnt <= rd_cnt + 1'b1;
         end
      end
   end

   a_level_bound: assert property (@(posedge msoc_clk) disable iff (!rstn)
      level <= FIFO_CNT_W'(FIFO_DEPTH))
      else $error("sync_fifo: fill level beyond depth");

endmodule

/* verilog/uart_core.sv */
//////////////////////////////////////////////////////////////////////
// UART serial core
// 8N1 transmitter and receiver, bit time set by baud_i in clock
// cycles. Receive line goes through a three-sample majority filter
// and each bit is sampled in its middle. A low stop bit sets err.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_core
   import periph_pkg::*;
(
   input  logic              msoc_clk,
   input  logic              rstn,
   input  logic [BAUD_W-1:0] baud_i,
   input  logic              tx_start_i,
   input  logic [7:0]        tx_byte_i,
   output logic              tx_busy_o,
   output logic              uart_tx_o,
   input  logic              uart_rx_i,
   output logic              rx_valid_o,
   output uart_rx_word_t     rx_word_o
);

   logic [BAUD_W-1:0] baud_last;
   logic [BAUD_W-1:0] baud_half;
   logic [BAUD_W-1:0] tx_cnt;
   logic [3:0]        tx_bit;
   logic [9:0]        tx_shift;
   logic [2:0]        rx_filt;
   logic              rx_maj;
   logic              rx_active;
   logic [BAUD_W-1:0] rx_cnt;
   logic [3:0]        rx_bit;
   logic [7:0]        rx_shift;
   logic              rx_stop;

   assign baud_last = baud_i - 1'b1;
   assign baud_half = baud_i >> 1;

   // transmitter
   assign uart_tx_o = tx_shift[0];            // shifts in ones, idles high

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_busy_o <= 1'b0;
         tx_cnt    <= '0;
         tx_bit    <= '0;
         tx_shift  <= '1;
      end
      else if (!tx_busy_o)
      begin
         if (tx_start_i)
         begin
            tx_shift  <= {1'b1, tx_byte_i, 1'b0}; // stop, data, start
            tx_busy_o <= 1'b1;
            tx_cnt    <= '0;
            tx_bit    <= '0;
         end
      end
      else if (tx_cnt == baud_last)
      begin
         tx_cnt   <= '0;
         tx_shift <= {1'b1, tx_shift[9:1]};
         if (tx_bit == 4'd9)
         begin
            tx_busy_o <= 1'b0;                // stop bit served
         end
         else
         begin
            tx_bit <= tx_bit + 1'b1;
         end
      end
      else
      begin
         tx_cnt <= tx_cnt + 1'b1;
      end
   end

   // receiver
   assign rx_maj = (rx_filt[0] & rx_filt[1]) | (rx_filt[0] & rx_filt[2]) |
                   (rx_filt[1] & rx_filt[2]);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         rx_filt    <= '1;
         rx_active  <= 1'b0;
         rx_cnt     <= '0;
         rx_bit     <= '0;
         rx_valid_o <= 1'b0;
      end
      else
      begin
         rx_filt    <= {rx_filt[1:0], uart_rx_i};
         rx_valid_o <= 1'b0;
         if (!rx_active)
         begin
            if (!rx_maj)
            begin
               rx_active <= 1'b1;             // falling edge, start bit
               rx_cnt    <= '0;
               rx_bit    <= '0;
            end
         end
         else
         begin
            if (rx_bit == 4'd0 && rx_cnt == baud_half && rx_maj)
            begin
               rx_active <= 1'b0;             // glitch, not a start bit
            end
            if (rx_cnt == baud_last)
            begin
               rx_cnt <= '0;
               if (rx_bit == 4'd9)
               begin
                  rx_active  <= 1'b0;
                  rx_valid_o <= 1'b1;         // one bit time into stop
               end
               else
               begin
                  rx_bit <= rx_bit + 1'b1;
               end
            end
            else
            begin
               rx_cnt <= rx_cnt + 1'b1;
            end
         end
      end
   end

   // mid-bit sampling of data and stop
   always_ff @(posedge msoc_clk)
   begin
      if (rx_active && rx_cnt == baud_half)
      begin
         if (rx_bit == 4'd9)
         begin
            rx_stop <= rx_maj;
         end
         else if (rx_bit != 4'd0)
         begin
            rx_shift <= {rx_maj, rx_shift[7:1]}; // lsb first
         end
      end
   end

   assign rx_word_o.err  = ~rx_stop;          // framing error
   assign rx_word_o.data = rx_shift;

endmodule

/* verilog/uart_regs.sv */
//////////////////////////////////////////////////////////////////////
// UART register block
// Decodes host writes into transmit push, receive pop and baud
// update. A small sequencer moves bytes from the transmit FIFO into
// the serial core, received words land in the receive FIFO.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_regs
   import periph_pkg::*;
(
   input  logic        msoc_clk,
   input  logic        rstn,
   input  host_req_t   req_i,
   input  logic        sel_i,
   input  logic        uart_rx_i,
   output logic        uart_tx_o,
   output host_rdata_t rdata_o
);

   typedef enum logic [2:0] {UTX_IDLE, UTX_EMPTY, UTX_POP, UTX_START, UTX_INUSE} utx_t;

   utx_t                  utx_q;
   utx_t                  utx_d;
   logic                  uart_wr;
   logic                  tx_push;
   logic                  rx_pop;
   logic [BAUD_W-1:0]     baud_q;
   logic [7:0]            tx_byte_q;
   logic                  tx_start;
   logic                  tx_busy;
   logic                  rx_valid;
   uart_rx_word_t         rx_word;
   uart_rx_word_t         rx_head;
   logic [8:0]            tx_fifo_dout;
   logic                  tx_full;
   logic                  tx_empty;
   logic                  rx_full;
   logic                  rx_empty;
   logic [FIFO_CNT_W-1:0] tx_wr_cnt;
   logic [FIFO_CNT_W-1:0] tx_rd_cnt;
   logic [FIFO_CNT_W-1:0] rx_wr_cnt;
   logic [FIFO_CNT_W-1:0] rx_rd_cnt;

   assign uart_wr = sel_i & req_i.en & (|req_i.we) & req_i.addr[UART_SEL_BIT];
   assign tx_push = uart_wr & (req_i.addr[13:12] == UART_OP_TX);
   assign rx_pop  = uart_wr & (req_i.addr[13:12] == UART_OP_POP);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         baud_q <= UART_BAUD_RESET;
         utx_q  <= UTX_IDLE;
      end
      else
      begin
         utx_q <= utx_d;
         if (uart_wr && req_i.addr[13:12] == UART_OP_BAUD)
         begin
            baud_q <= req_i.wdata[BAUD_W-1:0];
         end
      end
   end

   // head moves on after the pop, so hold the byte for the start cycle
   always_ff @(posedge msoc_clk)
   begin
      if (utx_q == UTX_POP)
      begin
         tx_byte_q <= tx_fifo_dout[7:0];
      end
   end

   always_comb
   begin
      utx_d = utx_q;
      case (utx_q)
         UTX_IDLE:  utx_d = UTX_EMPTY;
         UTX_EMPTY: if (!tx_empty) utx_d = UTX_POP;  // wait for data
         UTX_POP:   utx_d = UTX_START;
         UTX_START: utx_d = UTX_INUSE;
         UTX_INUSE: if (!tx_busy) utx_d = UTX_IDLE;  // frame done
         default:   utx_d = UTX_IDLE;
      endcase
   end

   assign tx_start = (utx_q == UTX_START);

   sync_fifo #(.WIDTH(9)) i_tx_fifo (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .push_i   (tx_push),
      .pop_i    (utx_q == UTX_POP),
      .din_i    ({1'b0, req_i.wdata[7:0]}),
      .dout_o   (tx_fifo_dout),
      .full_o   (tx_full),
      .empty_o  (tx_empty),
      .wr_cnt_o (tx_wr_cnt),
      .rd_cnt_o (tx_rd_cnt)
   );

   sync_fifo #(.WIDTH(9)) i_rx_fifo (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .push_i   (rx_valid),
      .pop_i    (rx_pop),
      .din_i    (rx_word),
      .dout_o   (rx_head),
      .full_o   (rx_full),
      .empty_o  (rx_empty),
      .wr_cnt_o (rx_wr_cnt),
      .rd_cnt_o (rx_rd_cnt)
   );

   uart_core i_uart_core (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .baud_i     (baud_q),
      .tx_start_i (tx_start),
      .tx_byte_i  (tx_byte_q),
      .tx_busy_o  (tx_busy),
      .uart_tx_o  (uart_tx_o),
      .uart_rx_i  (uart_rx_i),
      .rx_valid_o (rx_valid),
      .rx_word_o  (rx_word)
   );

   always_comb
   begin
      rdata_o = '0;                                  // keyboard range reads zero
      if (req_i.addr[UART_SEL_BIT])
      begin
         if (req_i.addr[13])
         begin
            rdata_o = {{(16-FIFO_CNT_W){1'b0}}, tx_wr_cnt,
                       {(16-FIFO_CNT_W){1'b0}}, tx_rd_cnt,
                       {(16-FIFO_CNT_W){1'b0}}, rx_wr_cnt,
                       {(16-FIFO_CNT_W){1'b0}}, rx_rd_cnt};
         end
         else
         begin
            rdata_o = {52'b0, rx_full, tx_full, rx_empty, rx_head};
         end
      end
   end

   a_no_start_busy: assert property (@(posedge msoc_clk) disable iff (!rstn)
      tx_start |-> !tx_busy)
      else $error("uart_regs: tx_start while transmitter busy");

endmodule

/* verilog/ctrl_regs.sv */
//////////////////////////////////////////////////////////////////////
// Control region registers
// LED output register and a registered copy of the DIP switches.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ctrl_regs
   import periph_pkg::*;
(
   input  logic        msoc_clk,
   input  logic        rstn,
   input  host_req_t   req_i,
   input  logic        sel_i,
   input  logic [15:0] from_dip_i,
   output logic [7:0]  to_led_o,
   output host_rdata_t rdata_o
);

   logic [4:0]  ofs;
   logic [15:0] dip_q;

   assign ofs = req_i.addr[7:3];

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         to_led_o <= '0;
         dip_q    <= '0;
      end
      else
      begin
         dip_q <= from_dip_i;                 // sampled every cycle
         if (sel_i && req_i.en && (|req_i.we) && ofs == CTRL_LED_OFS)
         begin
            to_led_o <= req_i.wdata[7:0];
         end
      end
   end

   always_comb
   begin
      case (ofs)
         CTRL_LED_OFS: rdata_o = {56'b0, to_led_o};
         CTRL_DIP_OFS: rdata_o = {48'b0, dip_q};
         default:      rdata_o = '0;
      endcase
   end

endmodule

/* verilog/bus_decode.sv */
//////////////////////////////////////////////////////////////////////
// Host bus region decoder
// One-hot peer selects from addr[17:15] and an OR-merge of the
// selected read words. Unmapped regions read zero.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_decode
   import periph_pkg::*;
(
   input  host_req_t   req_i,
   input  host_rdata_t uart_rdata_i,
   input  host_rdata_t ctrl_rdata_i,
   output logic        uart_sel_o,
   output logic        ctrl_sel_o,
   output host_rdata_t rdata_o
);

   logic [REGION_W-1:0] region;

   assign region = req_i.addr[17:15];

   // selects follow the address alone and peers qualify with en
   assign uart_sel_o = (region == REGION_UART);
   assign ctrl_sel_o = (region == REGION_CTRL);

   always_comb
   begin
      rdata_o = '0;
      if (uart_sel_o)
      begin
         rdata_o = rdata_o | uart_rdata_i;
      end
      if (ctrl_sel_o)
      begin
         rdata_o = rdata_o | ctrl_rdata_i;
      end
   end

endmodule

/* verilog/periph_soc.sv */
//////////////////////////////////////////////////////////////////////
// Peripheral SoC block
// Host bus slave with the UART path and the LED/DIP control region.
// Region decode merges the peer read words into hid_rddata_o.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module periph_soc
   import periph_pkg::*;
(
   input  logic        msoc_clk,
   input  logic        rstn,
   input  logic        hid_en_i,
   input  logic [7:0]  hid_we_i,
   input  logic [17:0] hid_addr_i,
   input  logic [63:0] hid_wrdata_i,
   output logic [63:0] hid_rddata_o,
   input  logic        uart_rx_i,
   output logic        uart_tx_o,
   input  logic [15:0] from_dip_i,
   output logic [7:0]  to_led_o
);

   host_req_t   host_req;
   host_rdata_t uart_rdata;
   host_rdata_t ctrl_rdata;
   logic        uart_sel;
   logic        ctrl_sel;

   assign host_req = '{en: hid_en_i, we: hid_we_i, addr: hid_addr_i, wdata: hid_wrdata_i};

   bus_decode i_bus_decode (
      .req_i        (host_req),
      .uart_rdata_i (uart_rdata),
      .ctrl_rdata_i (ctrl_rdata),
      .uart_sel_o   (uart_sel),
      .ctrl_sel_o   (ctrl_sel),
      .rdata_o      (hid_rddata_o)
   );

   uart_regs i_uart_regs (
      .msoc_clk  (msoc_clk),
      .rstn      (rstn),
      .req_i     (host_req),
      .sel_i     (uart_sel),
      .uart_rx_i (uart_rx_i),
      .uart_tx_o (uart_tx_o),
      .rdata_o   (uart_rdata)
   );

   ctrl_regs i_ctrl_regs (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .req_i      (host_req),
      .sel_i      (ctrl_sel),
      .from_dip_i (from_dip_i),
      .to_led_o   (to_led_o),
      .rdata_o    (ctrl_rdata)
   );

endmodule

/* verification/tb_periph_soc.sv */
//////////////////////////////////////////////////////////////////////
// Peripheral SoC testbench
// Table-driven checks of the region decode, LED/DIP control region
// and the UART path, with serial loopback or a bit-banged receive
// line, and a watchdog sized from the table length.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_periph_soc
   import periph_pkg::*;
;

   localparam int          TEST_BAUD = 8;
   localparam int          NUM_BYTES = 6;
   localparam int          POLL_MAX  = 24 * TEST_BAUD;  // reads per wait, a frame and then some
   localparam int          DRIVE_DLY = 2;
   localparam logic [31:0] LFSR_SEED = 32'h0a79_0674;

   localparam logic [17:0] UART_TX_A   = {REGION_UART, 1'b1, UART_OP_TX, 12'h000};
   localparam logic [17:0] UART_STAT_A = {REGION_UART, 1'b1, 2'b00, 12'h000};
   localparam logic [17:0] UART_POP_A  = {REGION_UART, 1'b1, UART_OP_POP, 12'h000};
   localparam logic [17:0] UART_BAUD_A = {REGION_UART, 1'b1, UART_OP_BAUD, 12'h000};
   localparam logic [17:0] UART_CNT_A  = {REGION_UART, 1'b1, 2'b10, 12'h000};
   localparam logic [17:0] CTRL_LED_A  = {REGION_CTRL, 7'h00, CTRL_LED_OFS, 3'b000};
   localparam logic [17:0] CTRL_DIP_A  = {REGION_CTRL, 7'h00, CTRL_DIP_OFS, 3'b000};
   localparam logic [63:0] FLAG_MASK   = 64'h0000_0000_0000_0e00; // head not yet written

   typedef enum logic [3:0] {OP_WR, OP_RD, OP_LED, OP_TXLINE, OP_DIP, OP_LOOP,
                             OP_WAIT_RXW, OP_WAIT_FRAME, OP_POP, OP_FRAME} op_t;

   typedef struct packed {
      op_t         op;
      logic [17:0] addr;
      logic [63:0] wdata;
      logic [63:0] exp;
      logic [63:0] mask;
   } row_t;

   logic        msoc_clk;
   logic        rstn;
   logic        hid_en;
   logic [7:0]  hid_we;
   logic [17:0] hid_addr;
   logic [63:0] hid_wrdata;
   host_rdata_t hid_rddata;
   logic        uart_rx;
   logic        uart_tx;
   logic [15:0] from_dip;
   logic [7:0]  to_led;
   logic        loop_en;
   logic        line_drv;
   logic        table_ready;
   logic [31:0] lfsr_q;
   row_t        rows[$];
   longint      wd_ns;
   int          err_cnt;
   int          fail_cnt;

   assign uart_rx = loop_en ? uart_tx : line_drv;      // loopback or bit-banged line

   periph_soc i_periph_soc (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .hid_en_i     (hid_en),
      .hid_we_i     (hid_we),
      .hid_addr_i   (hid_addr),
      .hid_wrdata_i (hid_wrdata),
      .hid_rddata_o (hid_rddata),
      .uart_rx_i    (uart_rx),
      .uart_tx_o    (uart_tx),
      .from_dip_i   (from_dip),
      .to_led_o     (to_led)
   );

   initial
   begin
      msoc_clk = 1'b0;
      forever #10 msoc_clk = ~msoc_clk;
   end

   // galois form, taps of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_byte(output logic [7:0] b);
      for (int i = 0; i < 8; i++)
      begin
         b[i]   = lfsr_q[0];                          // one step per bit
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   function automatic host_rdata_t cnt_word(input int tw, input int tr, input int rw,
                                            input int rr);
      cnt_word = {16'(tw), 16'(tr), 16'(rw), 16'(rr)};
   endfunction

   function automatic host_rdata_t status_word(input logic rxf, input logic txf,
                                               input logic rxe, input uart_rx_word_t w);
      status_word = {52'b0, rxf, txf, rxe, w};
   endfunction

   task automatic check_rdata(input string name, input host_rdata_t exp,
                              input host_rdata_t act, input host_rdata_t mask);
      if ((act & mask) !== (exp & mask))
      begin
         err_cnt++;
         $display("[ERROR] %s: expected %h, got %h (mask %h)", name, exp, act, mask);
      end
   endtask

   task automatic check_rx_word(input uart_rx_word_t exp, input uart_rx_word_t act);
      if (act !== exp)
      begin
         err_cnt++;
         $display("[ERROR] rx_word: expected %h, got %h", exp, act);
      end
   endtask

   task automatic check_led(input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
      begin
         err_cnt++;
         $display("[ERROR] to_led_o: expected %h, got %h", exp, act);
      end
   endtask

   task automatic check_line(input logic exp, input logic act);
      if (act !== exp)
      begin
         err_cnt++;
         $display("[ERROR] uart_tx_o: expected %h, got %h", exp, act);
      end
   endtask

   task automatic bus_write(input logic [17:0] addr, input logic [63:0] data);
      @(posedge msoc_clk);
      #DRIVE_DLY;
      hid_en     = 1'b1;
      hid_we     = 8'hff;
      hid_addr   = addr;
      hid_wrdata = data;
      @(posedge msoc_clk);                            // write lands here
      #DRIVE_DLY;
      hid_en = 1'b0;
      hid_we = 8'h00;
   endtask

   task automatic bus_read(input logic [17:0] addr, output host_rdata_t d);
      @(posedge msoc_clk);
      #DRIVE_DLY;
      hid_en   = 1'b1;
      hid_we   = 8'h00;
      hid_addr = addr;
      @(negedge msoc_clk);                            // combinational read, settled
      d = hid_rddata;
   endtask

   task automatic wait_rx_count(input logic [15:0] target);
      host_rdata_t d;
      int          polls;
      polls = 0;
      bus_read(UART_CNT_A, d);
      while (d[31:16] != target && polls < POLL_MAX)
      begin
         bus_read(UART_CNT_A, d);
         polls++;
      end
      if (d[31:16] != target)
      begin
         fail_cnt++;
         $display("rx write counter never reached %0d, it stays at %0d", target, d[31:16]);
      end
   endtask

   task automatic wait_frame_end();
      int polls;
      polls = 0;
      @(negedge msoc_clk);
      while (uart_tx === 1'b1 && polls < POLL_MAX)
      begin
         @(negedge msoc_clk);
         polls++;
      end
      if (uart_tx !== 1'b0)
      begin
         fail_cnt++;
         $display("no start bit appeared on the transmit line");
      end
      else
      begin
         repeat (11 * TEST_BAUD) @(posedge msoc_clk); // frame plus filter lag
      end
   endtask

   task automatic pop_and_check(input uart_rx_word_t exp);
      host_rdata_t d;
      bus_read(UART_STAT_A, d);
      check_rdata("rx_empty", '0, d, 64'h200);
      check_rx_word(exp, uart_rx_word_t'(d[8:0]));
      bus_write(UART_POP_A, '0);
   endtask

   task automatic drive_frame(input logic [7:0] data, input logic stop);
      logic [9:0] bits;
      bits = {stop, data, 1'b0};
      @(posedge msoc_clk);
      #DRIVE_DLY;
      for (int i = 0; i < 10; i++)
      begin
         line_drv = bits[i];
         repeat (TEST_BAUD) @(posedge msoc_clk);
         #DRIVE_DLY;
      end
      line_drv = 1'b1;
      repeat (2 * TEST_BAUD) @(posedge msoc_clk);    // idle gap
   endtask

   task automatic apply_row(input row_t r);
      host_rdata_t d;
      case (r.op)
         OP_WR:
         begin
            bus_write(r.addr, r.wdata);
         end
         OP_RD:
         begin
            bus_read(r.addr, d);
            check_rdata("hid_rddata_o", r.exp, d, r.mask);
         end
         OP_LED:
         begin
            @(negedge msoc_clk);
            check_led(r.exp[7:0], to_led);
         end
         OP_TXLINE:
         begin
            @(negedge msoc_clk);
            check_line(r.exp[0], uart_tx);
         end
         OP_DIP:
         begin
            @(posedge msoc_clk);
            #DRIVE_DLY;
            from_dip = r.wdata[15:0];
         end
         OP_LOOP:
         begin
            @(posedge msoc_clk);
            #DRIVE_DLY;
            loop_en = r.wdata[0];
         end
         OP_WAIT_RXW:   wait_rx_count(r.exp[15:0]);
         OP_WAIT_FRAME: wait_frame_end();
         OP_POP:        pop_and_check(uart_rx_word_t'(r.exp[8:0]));
         OP_FRAME:      drive_frame(r.wdata[7:0], r.wdata[8]);
         default:
         begin
            fail_cnt++;
            $display("table row holds an unknown operation");
         end
      endcase
   endtask

   task automatic add_row(input op_t op, input logic [17:0] addr, input logic [63:0] wdata,
                          input logic [63:0] exp, input logic [63:0] mask);
      row_t r;
      r = '{op: op, addr: addr, wdata: wdata, exp: exp, mask: mask};
      rows.push_back(r);
   endtask

   task automatic build_table();
      logic [7:0] b;
      logic [7:0] fill [17];
      int         k;
      int         n;
      lfsr_q = LFSR_SEED;
      n      = NUM_BYTES;
      // reset values
      add_row(OP_RD, UART_STAT_A, '0, status_word(1'b0, 1'b0, 1'b1, '0), FLAG_MASK);
      add_row(OP_RD, UART_CNT_A, '0, '0, '1);
      add_row(OP_RD, CTRL_LED_A, '0, '0, '1);
      add_row(OP_LED, '0, '0, '0, '1);
      add_row(OP_TXLINE, '0, '0, 64'h1, '1);
      // control region and unmapped space
      add_row(OP_WR, CTRL_LED_A, 64'h5a, '0, '0);
      add_row(OP_LED, '0, '0, 64'h5a, '1);
      add_row(OP_RD, CTRL_LED_A, '0, 64'h5a, '1);
      add_row(OP_WR, {3'd1, 15'h0078}, 64'hff, '0, '0); // must not reach the LED
      add_row(OP_LED, '0, '0, 64'h5a, '1);
      add_row(OP_DIP, '0, 64'hc3a5, '0, '0);
      add_row(OP_RD, CTRL_DIP_A, '0, 64'hc3a5, '1);
      add_row(OP_RD, {REGION_CTRL, 15'h0000}, '0, '0, '1);
      for (k = 1; k < 8; k++)
      begin
         if (k != 2)
         begin
            add_row(OP_RD, {3'(k), 15'h4078}, '0, '0, '1);
         end
      end
      add_row(OP_RD, {REGION_UART, 15'h0000}, '0, '0, '1);   // keyboard range
      add_row(OP_RD, {REGION_UART, 15'h2008}, '0, '0, '1);
      // loopback, byte by byte
      add_row(OP_LOOP, '0, 64'h1, '0, '0);
      add_row(OP_WR, UART_BAUD_A, 64'(TEST_BAUD), '0, '0);
      for (k = 0; k < n; k++)
      begin
         take_byte(b);
         add_row(OP_WR, UART_TX_A, {56'b0, b}, '0, '0);
         add_row(OP_WAIT_RXW, '0, '0, 64'(k + 1), '0);
         add_row(OP_POP, '0, '0, {55'b0, 1'b0, b}, '0);
      end
      add_row(OP_RD, UART_CNT_A, '0, cnt_word(n, n, n, n), '1);
      // fill the receive FIFO, the 17th byte is dropped
      for (k = 0; k < 17; k++)
      begin
         take_byte(fill[k]);
         add_row(OP_WR, UART_TX_A, {56'b0, fill[k]}, '0, '0);
         if (k < 16)
         begin
            add_row(OP_WAIT_RXW, '0, '0, 64'(n + k + 1), '0);
         end
         else
         begin
            add_row(OP_WAIT_FRAME, '0, '0, '0, '0);
         end
      end
      add_row(OP_RD, UART_CNT_A, '0, cnt_word(n + 17, n + 17, n + 16, n), '1);
      add_row(OP_RD, UART_STAT_A, '0, status_word(1'b1, 1'b0, 1'b0, {1'b0, fill[0]}), '1);
      for (k = 0; k < 16; k++)
      begin
         add_row(OP_POP, '0, '0, {55'b0, 1'b0, fill[k]}, '0);
      end
      // driven frame with a low stop bit
      add_row(OP_LOOP, '0, '0, '0, '0);
      take_byte(b);
      add_row(OP_FRAME, '0, {55'b0, 1'b0, b}, '0, '0);
      add_row(OP_WAIT_RXW, '0, '0, 64'(n + 17), '0);
      add_row(OP_POP, '0, '0, {55'b0, 1'b1, b}, '0);
      // pop of an empty receive FIFO
      add_row(OP_RD, UART_STAT_A, '0, status_word(1'b0, 1'b0, 1'b1, '0), FLAG_MASK);
      add_row(OP_WR, UART_POP_A, '0, '0, '0);
      add_row(OP_RD, UART_CNT_A, '0, cnt_word(n + 17, n + 17, n + 17, n + 17), '1);
      add_row(OP_RD, UART_STAT_A, '0, status_word(1'b0, 1'b0, 1'b1, '0), FLAG_MASK);
   endtask

   initial
   begin
      wait (table_ready === 1'b1);
      #(wd_ns);
      $display("watchdog expired after %0d ns before the table was done", wd_ns);
      $display("Simulation failed");
      $finish;
   end

   initial
   begin
      int i;
      rstn        = 1'b0;
      hid_en      = 1'b0;
      hid_we      = 8'h00;
      hid_addr    = '0;
      hid_wrdata  = '0;
      from_dip    = '0;
      loop_en     = 1'b1;
      line_drv    = 1'b1;
      table_ready = 1'b0;
      err_cnt     = 0;
      fail_cnt    = 0;
      build_table();
      wd_ns       = longint'(rows.size() + 20) * 12 * TEST_BAUD * 20 * 2;
      table_ready = 1'b1;
      repeat (10) @(posedge msoc_clk);
      #DRIVE_DLY;
      rstn = 1'b1;
      for (i = 0; i < rows.size(); i++)
      begin
         apply_row(rows[i]);
      end
      repeat (4) @(posedge msoc_clk);
      $display("value errors: %0d, other errors: %0d", err_cnt, fail_cnt);
      if (err_cnt == 0 && fail_cnt == 0)
      begin
         $display("Simulation passed");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* periph_soc.f */
verilog/periph_pkg.sv
verilog/sync_fifo.sv
verilog/uart_core.sv
verilog/uart_regs.sv
verilog/ctrl_regs.sv
verilog/bus_decode.sv
verilog/periph_soc.sv
verification/tb_periph_soc.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the periph_soc testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_periph_soc \
   -f periph_soc.f -o tb_periph_soc > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_periph_soc > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
